// ==== logic/mem_bus_pkg.sv ====
// ==========================================================================
// Memory request bus types
// ==========================================================================

package mem_bus_pkg;

	// Physical address width
	parameter int ADDR_W = 32;

	// Byte offset inside a 64-byte cache line
	parameter int LINE_OFS_W = 6;

	// Memory address
	typedef logic [ADDR_W-1:0] addr_t;

	// One data word, every access is a full 32-bit word
	typedef logic [31:0] word_t;

	// Transaction id stamped by the arbiter
	typedef logic [7:0] tid_t;

	// Request function carried on the bus and echoed in responses
	typedef enum logic [1:0] {
		MR_LOAD        = 2'd0,
		MR_LOADZ       = 2'd1,
		MR_STORE       = 2'd2,
		MR_ICACHE_LOAD = 2'd3
	} mem_func_e;

endpackage

// ==== logic/core_pkg.sv ====
// ==========================================================================
// Core side load/store types
// ==========================================================================

package core_pkg;

	// Scalar load/store operation from execute
	typedef enum logic [1:0] {
		LDST_LOAD  = 2'd0,
		LDST_LOADU = 2'd1,
		LDST_STORE = 2'd2
	} ldst_op_e;

	// Address formation
	// reg+imm or reg+reg
	typedef enum logic {
		AM_REG_IMM = 1'b0,
		AM_REG_REG = 1'b1
	} addr_mode_e;

	// Per-thread slot lifecycle
	typedef enum logic [1:0] {
		SLOT_IDLE = 2'd0,
		SLOT_PEND = 2'd1,
		SLOT_OUT  = 2'd2
	} slot_state_e;

endpackage

// ==== logic/icache_miss_req.sv ====
`timescale 1ns/10ps

module icache_miss_req #(
	parameter int NTHREADS = 4
) (
	input  logic                         clk_g,
	input  logic                         rst_i,
	input  logic                         fetch_miss_i,
	input  logic [TW-1:0]                fetch_thread_i,
	input  mem_bus_pkg::addr_t           fetch_adr_i,
	input  logic                         icm_gnt_i,
	output logic                         icm_req_o,
	output mem_bus_pkg::addr_t           icm_adr_o,
	output logic [TW-1:0]                icm_rid_o
);

	localparam int TW = (NTHREADS > 1) ? $clog2(NTHREADS) : 1;
	localparam int LINE_W = mem_bus_pkg::ADDR_W - mem_bus_pkg::LINE_OFS_W;

	// Line number of the last miss sent to memory
	logic [LINE_W-1:0] last_line;
	logic              new_miss;

	// Only a different line is worth a reload
	// A miss seen while one is still waiting is dropped
	assign new_miss = fetch_miss_i && !icm_req_o &&
		(fetch_adr_i[mem_bus_pkg::ADDR_W-1:mem_bus_pkg::LINE_OFS_W] != last_line);

	// Request level held until granted
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			icm_req_o <= 1'b0;
			last_line <= '0;
		end else begin
			if (icm_gnt_i)
				icm_req_o <= 1'b0;
			if (new_miss) begin
				icm_req_o <= 1'b1;
				last_line <= fetch_adr_i[mem_bus_pkg::ADDR_W-1:mem_bus_pkg::LINE_OFS_W];
			end
		end
	end

	// Line aligned address and owning thread
	always_ff @(posedge clk_g) begin
		if (new_miss) begin
			icm_adr_o <= {fetch_adr_i[mem_bus_pkg::ADDR_W-1:mem_bus_pkg::LINE_OFS_W],
				{mem_bus_pkg::LINE_OFS_W{1'b0}}};
			icm_rid_o <= fetch_thread_i;
		end
	end

	// Grants only ever answer a raised request
	a_gnt_needs_req: assert property (@(posedge clk_g) disable iff (rst_i)
		icm_gnt_i |-> icm_req_o);

endmodule

// ==== logic/ldst_agen.sv ====
`timescale 1ns/10ps

module ldst_agen #(
	parameter int NTHREADS = 4
) (
	input  logic                         clk_g,
	input  logic                         rst_i,
	input  logic                         ldst_i,
	input  logic [TW-1:0]                ldst_thread_i,
	input  core_pkg::ldst_op_e           ldst_op_i,
	input  core_pkg::addr_mode_e         ldst_mode_i,
	input  mem_bus_pkg::word_t           ldst_base_i,
	input  mem_bus_pkg::word_t           ldst_index_i,
	input  mem_bus_pkg::word_t           ldst_imm_i,
	input  mem_bus_pkg::word_t           ldst_st_data_i,
	input  logic                         ag_gnt_i,
	input  logic                         mem_resp_v_i,
	input  mem_bus_pkg::mem_func_e       mem_resp_func_i,
	input  logic [TW-1:0]                mem_resp_rid_i,
	input  mem_bus_pkg::word_t           mem_resp_dat_i,
	output logic                         ag_req_o,
	output mem_bus_pkg::mem_func_e       ag_func_o,
	output mem_bus_pkg::addr_t           ag_adr_o,
	output mem_bus_pkg::word_t           ag_dat_o,
	output logic [TW-1:0]                ag_rid_o,
	output logic [NTHREADS-1:0]          thread_busy_o,
	output logic                         ld_done_o,
	output logic [TW-1:0]                ld_thread_o,
	output mem_bus_pkg::word_t           ld_data_o
);

	localparam int TW = (NTHREADS > 1) ? $clog2(NTHREADS) : 1;

	// ======================================================================
	// Per-thread slots
	// ======================================================================
	core_pkg::slot_state_e  slot_st   [NTHREADS];
	mem_bus_pkg::addr_t     slot_adr  [NTHREADS];
	mem_bus_pkg::mem_func_e slot_func [NTHREADS];
	mem_bus_pkg::word_t     slot_dat  [NTHREADS];

	mem_bus_pkg::addr_t     eff_adr;
	mem_bus_pkg::mem_func_e op_func;
	logic [TW-1:0]          last_gnt;
	logic [TW-1:0]          sel;
	logic                   resp_data;

	// Base plus immediate or base plus index
	assign eff_adr = ldst_base_i +
		((ldst_mode_i == core_pkg::AM_REG_REG) ? ldst_index_i : ldst_imm_i);

	// Operation to bus function
	always_comb begin
		case (ldst_op_i)
			core_pkg::LDST_LOADU: op_func = mem_bus_pkg::MR_LOADZ;
			core_pkg::LDST_STORE: op_func = mem_bus_pkg::MR_STORE;
			default:              op_func = mem_bus_pkg::MR_LOAD;
		endcase
	end

	// Line reloads belong to fetch and pass by
	assign resp_data = mem_resp_v_i && (mem_resp_func_i != mem_bus_pkg::MR_ICACHE_LOAD);

	// ======================================================================
	// Round-robin pick among pending slots
	// ======================================================================
	always_comb begin
		int rr_idx;
		rr_idx = 0;
		ag_req_o = 1'b0;
		sel = '0;
		// Scan starts one past the thread last granted
		for (int i = 1; i <= NTHREADS; i++) begin
			rr_idx = (int'(last_gnt) + i) % NTHREADS;
			if (!ag_req_o && slot_st[rr_idx] == core_pkg::SLOT_PEND) begin
				ag_req_o = 1'b1;
				sel = TW'(rr_idx);
			end
		end
	end

	assign ag_func_o = slot_func[sel];
	assign ag_adr_o  = slot_adr[sel];
	assign ag_dat_o  = slot_dat[sel];
	assign ag_rid_o  = sel;

	// A thread is busy from strobe until its response
	always_comb begin
		for (int t = 0; t < NTHREADS; t++)
			thread_busy_o[t] = (slot_st[t] != core_pkg::SLOT_IDLE);
	end

	// Slot state, pointer and completion strobe
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			for (int t = 0; t < NTHREADS; t++)
				slot_st[t] <= core_pkg::SLOT_IDLE;
			// Thread 0 is first in line after reset
			last_gnt <= TW'(NTHREADS - 1);
			ld_done_o <= 1'b0;
		end else begin
			ld_done_o <= 1'b0;
			if (ldst_i)
				slot_st[ldst_thread_i] <= core_pkg::SLOT_PEND;
			if (ag_gnt_i) begin
				slot_st[sel] <= core_pkg::SLOT_OUT;
				last_gnt <= sel;
			end
			if (resp_data) begin
				slot_st[mem_resp_rid_i] <= core_pkg::SLOT_IDLE;
				ld_done_o <= 1'b1;
			end
		end
	end

	// Slot payload and returned data
	always_ff @(posedge clk_g) begin
		if (ldst_i) begin
			slot_adr[ldst_thread_i]  <= eff_adr;
			slot_func[ldst_thread_i] <= op_func;
			slot_dat[ldst_thread_i]  <= ldst_st_data_i;
		end
		if (resp_data) begin
			ld_thread_o <= mem_resp_rid_i;
			ld_data_o   <= mem_resp_dat_i;
		end
	end

	// Execute must wait for the thread to drain
	a_no_busy_strobe: assert property (@(posedge clk_g) disable iff (rst_i)
		ldst_i |-> !thread_busy_o[ldst_thread_i]);

	// Memory answers only what was issued
	a_resp_outstanding: assert property (@(posedge clk_g) disable iff (rst_i)
		resp_data |-> (slot_st[mem_resp_rid_i] == core_pkg::SLOT_OUT));

endmodule

// ==== logic/mem_req_arbiter.sv ====
`timescale 1ns/10ps

module mem_req_arbiter #(
	parameter int NTHREADS = 4
) (
	input  logic                         clk_g,
	input  logic                         rst_i,
	input  logic                         mem_full_i,
	input  logic                         ag_req_i,
	input  mem_bus_pkg::mem_func_e       ag_func_i,
	input  mem_bus_pkg::addr_t           ag_adr_i,
	input  mem_bus_pkg::word_t           ag_dat_i,
	input  logic [TW-1:0]                ag_rid_i,
	input  logic                         icm_req_i,
	input  mem_bus_pkg::addr_t           icm_adr_i,
	input  logic [TW-1:0]                icm_rid_i,
	output logic                         ag_gnt_o,
	output logic                         icm_gnt_o,
	output logic                         mem_req_wr_o,
	output mem_bus_pkg::mem_func_e       mem_req_func_o,
	output mem_bus_pkg::addr_t           mem_req_adr_o,
	output mem_bus_pkg::word_t           mem_req_dat_o,
	output mem_bus_pkg::tid_t            mem_req_tid_o,
	output logic [TW-1:0]                mem_req_rid_o
);

	localparam int TW = (NTHREADS > 1) ? $clog2(NTHREADS) : 1;

	// Next transaction id to hand out
	mem_bus_pkg::tid_t tid_q;

	// Load/store first and line loads fill the gaps
	// Nothing goes while memory is full
	assign ag_gnt_o  = ag_req_i && !mem_full_i;
	assign icm_gnt_o = icm_req_i && !ag_req_i && !mem_full_i;

	// Write strobe and id counter
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			mem_req_wr_o <= 1'b0;
			tid_q <= 8'd1;
		end else begin
			mem_req_wr_o <= ag_gnt_o || icm_gnt_o;
			if (ag_gnt_o || icm_gnt_o)
				tid_q <= tid_q + 8'd1;
		end
	end

	// Winner onto the bus
	always_ff @(posedge clk_g) begin
		if (ag_gnt_o) begin
			mem_req_func_o <= ag_func_i;
			mem_req_adr_o  <= ag_adr_i;
			mem_req_dat_o  <= ag_dat_i;
			mem_req_rid_o  <= ag_rid_i;
			mem_req_tid_o  <= tid_q;
		end else if (icm_gnt_o) begin
			mem_req_func_o <= mem_bus_pkg::MR_ICACHE_LOAD;
			mem_req_adr_o  <= icm_adr_i;
			// No victim data in this slice
			mem_req_dat_o  <= '0;
			mem_req_rid_o  <= icm_rid_i;
			mem_req_tid_o  <= tid_q;
		end
	end

	// A losing line request waits unchanged for its turn
	a_icm_held: assert property (@(posedge clk_g) disable iff (rst_i)
		(icm_req_i && !icm_gnt_o) |=> (icm_req_i && $stable(icm_adr_i)));

endmodule

// ==== logic/mem_front_top.sv ====
`timescale 1ns/10ps

module mem_front_top #(
	parameter int NTHREADS = 4
) (
	input  logic                         clk_g,
	input  logic                         rst_i,
	// Fetch miss
	input  logic                         fetch_miss_i,
	input  logic [TW-1:0]                fetch_thread_i,
	input  mem_bus_pkg::addr_t           fetch_adr_i,
	// Execute load/store
	input  logic                         ldst_i,
	input  logic [TW-1:0]                ldst_thread_i,
	input  core_pkg::ldst_op_e           ldst_op_i,
	input  core_pkg::addr_mode_e         ldst_mode_i,
	input  mem_bus_pkg::word_t           ldst_base_i,
	input  mem_bus_pkg::word_t           ldst_index_i,
	input  mem_bus_pkg::word_t           ldst_imm_i,
	input  mem_bus_pkg::word_t           ldst_st_data_i,
	output logic [NTHREADS-1:0]          thread_busy_o,
	output logic                         ld_done_o,
	output logic [TW-1:0]                ld_thread_o,
	output mem_bus_pkg::word_t           ld_data_o,
	// Memory side
	input  logic                         mem_full_i,
	input  logic                         mem_resp_v_i,
	input  mem_bus_pkg::mem_func_e       mem_resp_func_i,
	input  logic [TW-1:0]                mem_resp_rid_i,
	input  mem_bus_pkg::word_t           mem_resp_dat_i,
	output logic                         mem_req_wr_o,
	output mem_bus_pkg::mem_func_e       mem_req_func_o,
	output mem_bus_pkg::addr_t           mem_req_adr_o,
	output mem_bus_pkg::word_t           mem_req_dat_o,
	output mem_bus_pkg::tid_t            mem_req_tid_o,
	output logic [TW-1:0]                mem_req_rid_o
);

	localparam int TW = (NTHREADS > 1) ? $clog2(NTHREADS) : 1;

	// ======================================================================
	// Requester to arbiter wiring
	// ======================================================================
	logic                   icm_req, icm_gnt;
	mem_bus_pkg::addr_t     icm_adr;
	logic [TW-1:0]          icm_rid;
	logic                   ag_req, ag_gnt;
	mem_bus_pkg::mem_func_e ag_func;
	mem_bus_pkg::addr_t     ag_adr;
	mem_bus_pkg::word_t     ag_dat;
	logic [TW-1:0]          ag_rid;

	icache_miss_req #(.NTHREADS(NTHREADS)) u_icm (
		.clk_g(clk_g), .rst_i(rst_i),
		.fetch_miss_i(fetch_miss_i), .fetch_thread_i(fetch_thread_i),
		.fetch_adr_i(fetch_adr_i), .icm_gnt_i(icm_gnt),
		.icm_req_o(icm_req), .icm_adr_o(icm_adr), .icm_rid_o(icm_rid)
	);

	ldst_agen #(.NTHREADS(NTHREADS)) u_agen (
		.clk_g(clk_g), .rst_i(rst_i),
		.ldst_i(ldst_i), .ldst_thread_i(ldst_thread_i),
		.ldst_op_i(ldst_op_i), .ldst_mode_i(ldst_mode_i),
		.ldst_base_i(ldst_base_i), .ldst_index_i(ldst_index_i),
		.ldst_imm_i(ldst_imm_i), .ldst_st_data_i(ldst_st_data_i),
		.ag_gnt_i(ag_gnt), .mem_resp_v_i(mem_resp_v_i),
		.mem_resp_func_i(mem_resp_func_i), .mem_resp_rid_i(mem_resp_rid_i),
		.mem_resp_dat_i(mem_resp_dat_i),
		.ag_req_o(ag_req), .ag_func_o(ag_func), .ag_adr_o(ag_adr),
		.ag_dat_o(ag_dat), .ag_rid_o(ag_rid), .thread_busy_o(thread_busy_o),
		.ld_done_o(ld_done_o), .ld_thread_o(ld_thread_o), .ld_data_o(ld_data_o)
	);

	mem_req_arbiter #(.NTHREADS(NTHREADS)) u_arb (
		.clk_g(clk_g), .rst_i(rst_i), .mem_full_i(mem_full_i),
		.ag_req_i(ag_req), .ag_func_i(ag_func), .ag_adr_i(ag_adr),
		.ag_dat_i(ag_dat), .ag_rid_i(ag_rid),
		.icm_req_i(icm_req), .icm_adr_i(icm_adr), .icm_rid_i(icm_rid),
		.ag_gnt_o(ag_gnt), .icm_gnt_o(icm_gnt),
		.mem_req_wr_o(mem_req_wr_o), .mem_req_func_o(mem_req_func_o),
		.mem_req_adr_o(mem_req_adr_o), .mem_req_dat_o(mem_req_dat_o),
		.mem_req_tid_o(mem_req_tid_o), .mem_req_rid_o(mem_req_rid_o)
	);

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 3
) (
	output logic clk_g,
	output logic rst_o
);

	// Free running clock
	initial begin
		clk_g = 1'b0;
		forever #(PERIOD_NS / 2) clk_g = ~clk_g;
	end

	// Reset covers the first rising edges
	// Released just after an edge like any other input
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_g);
		#2 rst_o = 1'b0;
	end

endmodule

// ==== sim/tb_mem_front.sv ====
`timescale 1ns/10ps

module tb_mem_front;

	localparam int NT = 4;
	localparam int TW = $clog2(NT);
	localparam int CLK_NS = 40;
	localparam int MEM_LAT = 3;
	// Rough length of all tests in cycles plus slack
	localparam int TEST_CYCLES = 120;
	localparam int SLACK_CYCLES = 80;

	logic                   clk_g;
	logic                   rst;
	logic                   fetch_miss = 1'b0;
	logic [TW-1:0]          fetch_thread = '0;
	mem_bus_pkg::addr_t     fetch_adr = '0;
	logic                   ldst = 1'b0;
	logic [TW-1:0]          ldst_thread = '0;
	core_pkg::ldst_op_e     ldst_op = core_pkg::LDST_LOAD;
	core_pkg::addr_mode_e   ldst_mode = core_pkg::AM_REG_IMM;
	mem_bus_pkg::word_t     ldst_base = '0;
	mem_bus_pkg::word_t     ldst_index = '0;
	mem_bus_pkg::word_t     ldst_imm = '0;
	mem_bus_pkg::word_t     ldst_st_data = '0;
	logic                   mem_full = 1'b0;
	logic                   mem_resp_v = 1'b0;
	mem_bus_pkg::mem_func_e mem_resp_func = mem_bus_pkg::MR_LOAD;
	logic [TW-1:0]          mem_resp_rid = '0;
	mem_bus_pkg::word_t     mem_resp_dat = '0;
	logic [NT-1:0]          thread_busy;
	logic                   ld_done;
	logic [TW-1:0]          ld_thread;
	mem_bus_pkg::word_t     ld_data;
	logic                   mem_req_wr;
	mem_bus_pkg::mem_func_e mem_req_func;
	mem_bus_pkg::addr_t     mem_req_adr;
	mem_bus_pkg::word_t     mem_req_dat;
	mem_bus_pkg::tid_t      mem_req_tid;
	logic [TW-1:0]          mem_req_rid;

	// ======================================================================
	// Expected traffic and memory model state
	// ======================================================================
	// Entry layout {check data, func, address, data, rid}
	logic [68:0]            exp_q[$];
	int                     exp_rd = 0;
	logic                   exp_valid = 1'b0;
	logic [68:0]            exp_head = '0;
	mem_bus_pkg::tid_t      exp_tid = 8'd1;
	logic                   wr_seen = 1'b0;
	int                     cyc = 0;
	int                     resp_due[$];
	mem_bus_pkg::mem_func_e resp_func[$];
	logic [TW+31:0]         resp_word[$];
	int                     resp_rd = 0;
	// Response and strobe echoes delayed one stage per cycle
	logic [TW+32:0]         rsp_now = '0;
	logic [TW+32:0]         done_exp = '0;
	logic [TW:0]            st_now = '0;
	logic [TW:0]            st_exp = '0;
	logic [67:0]            got_req;
	logic [67:0]            req_mask;
	logic                   resp_data;
	int                     seed = 32'hbf5e_0549;
	int                     mismatch_cnt = 0;
	int                     fail_cnt = 0;
	string                  test_name = "reset";
	logic [68:0]            ent [NT];
	logic [68:0]            line_ent;
	mem_bus_pkg::addr_t     line_adr;

	tb_clock #(.PERIOD_NS(CLK_NS), .RST_CYCLES(3)) u_clk (.clk_g(clk_g), .rst_o(rst));

	mem_front_top #(.NTHREADS(NT)) dut_i (
		.clk_g(clk_g), .rst_i(rst),
		.fetch_miss_i(fetch_miss), .fetch_thread_i(fetch_thread), .fetch_adr_i(fetch_adr),
		.ldst_i(ldst), .ldst_thread_i(ldst_thread), .ldst_op_i(ldst_op),
		.ldst_mode_i(ldst_mode), .ldst_base_i(ldst_base), .ldst_index_i(ldst_index),
		.ldst_imm_i(ldst_imm), .ldst_st_data_i(ldst_st_data),
		.thread_busy_o(thread_busy), .ld_done_o(ld_done), .ld_thread_o(ld_thread),
		.ld_data_o(ld_data), .mem_full_i(mem_full), .mem_resp_v_i(mem_resp_v),
		.mem_resp_func_i(mem_resp_func), .mem_resp_rid_i(mem_resp_rid),
		.mem_resp_dat_i(mem_resp_dat), .mem_req_wr_o(mem_req_wr),
		.mem_req_func_o(mem_req_func), .mem_req_adr_o(mem_req_adr),
		.mem_req_dat_o(mem_req_dat), .mem_req_tid_o(mem_req_tid),
		.mem_req_rid_o(mem_req_rid)
	);

	assign got_req   = {mem_req_func, mem_req_adr, mem_req_dat, mem_req_rid};
	// Load data on the bus is a don't care
	assign req_mask  = {2'b11, 32'hffff_ffff, {32{exp_head[68]}}, {TW{1'b1}}};
	assign resp_data = mem_resp_v && (mem_resp_func != mem_bus_pkg::MR_ICACHE_LOAD);

	// Memory contents as a function of the full address
	function automatic mem_bus_pkg::word_t mem_word(input mem_bus_pkg::addr_t adr);
		return {adr[15:0], adr[31:16]} ^ 32'h6b3d_91c5;
	endfunction

	// Bookkeeping on the falling edge so the checks see settled values
	// A request is retired one negedge after it was seen
	always @(negedge clk_g) begin
		if (wr_seen) begin
			exp_rd++;
			exp_tid++;
		end
		wr_seen = mem_req_wr && !rst;
		if (wr_seen) begin
			resp_due.push_back(cyc + MEM_LAT);
			resp_func.push_back(mem_req_func);
			resp_word.push_back({mem_req_rid, mem_word(mem_req_adr)});
		end
		exp_valid = (exp_rd < exp_q.size());
		exp_head  = exp_valid ? exp_q[exp_rd] : '0;
		done_exp  = rsp_now;
		rsp_now   = {resp_data, mem_resp_rid, mem_resp_dat};
		st_exp    = st_now;
		st_now    = {ldst, ldst_thread};
		cyc++;
	end

	// Memory answers in request order after a fixed latency
	always @(posedge clk_g) begin
		#2;
		mem_resp_v = 1'b0;
		if (resp_rd < resp_due.size() && resp_due[resp_rd] <= cyc) begin
			mem_resp_func = resp_func[resp_rd];
			{mem_resp_rid, mem_resp_dat} = resp_word[resp_rd];
			mem_resp_v = 1'b1;
			resp_rd++;
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================
	a_req_expected: assert property (@(posedge clk_g) disable iff (rst)
		mem_req_wr |-> exp_valid)
		else begin
			fail_cnt++;
			$display("%s: request issued with none expected", test_name);
		end

	a_req_value: assert property (@(posedge clk_g) disable iff (rst)
		(mem_req_wr && exp_valid) |-> ((got_req & req_mask) == (exp_head[67:0] & req_mask)))
		else begin
			mismatch_cnt++;
			$display("MISMATCH %s request: expected %h actual %h", test_name,
				exp_head[67:0], $sampled(got_req));
		end

	a_tid: assert property (@(posedge clk_g) disable iff (rst)
		mem_req_wr |-> (mem_req_tid == exp_tid))
		else begin
			mismatch_cnt++;
			$display("MISMATCH %s tid: expected %0d actual %0d", test_name,
				exp_tid, $sampled(mem_req_tid));
		end

	a_full_stall: assert property (@(posedge clk_g) disable iff (rst)
		mem_full |=> !mem_req_wr)
		else begin
			fail_cnt++;
			$display("%s: request issued while memory was full", test_name);
		end

	a_done_flag: assert property (@(posedge clk_g) disable iff (rst)
		ld_done == done_exp[TW+32])
		else begin
			mismatch_cnt++;
			$display("MISMATCH %s ld_done: expected %b actual %b", test_name,
				done_exp[TW+32], $sampled(ld_done));
		end

	a_done_value: assert property (@(posedge clk_g) disable iff (rst)
		done_exp[TW+32] |-> ({ld_thread, ld_data} == done_exp[TW+31:0]))
		else begin
			mismatch_cnt++;
			$display("MISMATCH %s load result: expected %h actual %h", test_name,
				done_exp[TW+31:0], $sampled({ld_thread, ld_data}));
		end

	a_busy_clear: assert property (@(posedge clk_g) disable iff (rst)
		done_exp[TW+32] |-> !thread_busy[done_exp[TW+31:32]])
		else begin
			fail_cnt++;
			$display("%s: busy bit still set after the response", test_name);
		end

	a_busy_set: assert property (@(posedge clk_g) disable iff (rst)
		st_exp[TW] |-> thread_busy[st_exp[TW-1:0]])
		else begin
			fail_cnt++;
			$display("%s: busy bit not set after a strobe", test_name);
		end

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic next_cycle();
		@(posedge clk_g);
		#2;
		ldst = 1'b0;
		fetch_miss = 1'b0;
	endtask

	// Random operands and the expected request from the addressing rule
	task automatic drive_ldst(input logic [TW-1:0] t, input core_pkg::ldst_op_e op,
		input core_pkg::addr_mode_e mode, output logic [68:0] exp_ent);
		mem_bus_pkg::mem_func_e func;
		mem_bus_pkg::addr_t     adr;
		ldst_base    = $random(seed);
		ldst_index   = $random(seed);
		ldst_imm     = $random(seed);
		ldst_st_data = $random(seed);
		ldst_thread  = t;
		ldst_op      = op;
		ldst_mode    = mode;
		ldst         = 1'b1;
		case (op)
			core_pkg::LDST_LOADU: func = mem_bus_pkg::MR_LOADZ;
			core_pkg::LDST_STORE: func = mem_bus_pkg::MR_STORE;
			default:              func = mem_bus_pkg::MR_LOAD;
		endcase
		if (mode == core_pkg::AM_REG_REG)
			adr = ldst_base + ldst_index;
		else
			adr = ldst_base + ldst_imm;
		exp_ent = {op == core_pkg::LDST_STORE, func, adr, ldst_st_data, t};
	endtask

	// Line load request on the 64-byte boundary with zero data
	task automatic drive_miss(input logic [TW-1:0] t, input mem_bus_pkg::addr_t adr,
		output logic [68:0] exp_ent);
		fetch_thread = t;
		fetch_adr    = adr;
		fetch_miss   = 1'b1;
		exp_ent = {1'b1, mem_bus_pkg::MR_ICACHE_LOAD, adr[31:6], 6'b0, 32'h0, t};
	endtask

	task automatic wait_idle();
		while (exp_rd < exp_q.size() || resp_rd < resp_due.size() || thread_busy != '0)
			next_cycle();
		// Longer than the strobe to bus latency
		repeat (4) next_cycle();
	endtask

	initial begin
		@(negedge rst);
		next_cycle();
		assert (thread_busy == '0 && !mem_req_wr && !ld_done)
		else begin
			fail_cnt++;
			$display("outputs not idle after reset");
		end

		// New line and then the same line at another offset
		test_name = "fetch_miss";
		line_adr = $random(seed);
		line_adr[20] = 1'b1;
		drive_miss(2'd1, line_adr, line_ent);
		exp_q.push_back(line_ent);
		next_cycle();
		wait_idle();
		drive_miss(2'd1, line_adr ^ 32'h0000_0014, line_ent);
		next_cycle();
		wait_idle();

		// Every operation and mode with all threads outstanding together
		test_name = "ldst_ops";
		drive_ldst(2'd0, core_pkg::LDST_LOAD, core_pkg::AM_REG_IMM, ent[0]);
		exp_q.push_back(ent[0]);
		next_cycle();
		drive_ldst(2'd1, core_pkg::LDST_LOADU, core_pkg::AM_REG_REG, ent[1]);
		exp_q.push_back(ent[1]);
		next_cycle();
		drive_ldst(2'd2, core_pkg::LDST_STORE, core_pkg::AM_REG_IMM, ent[2]);
		exp_q.push_back(ent[2]);
		next_cycle();
		drive_ldst(2'd3, core_pkg::LDST_STORE, core_pkg::AM_REG_REG, ent[3]);
		exp_q.push_back(ent[3]);
		next_cycle();
		wait_idle();

		// Load beats the line request in the same cycle
		test_name = "priority";
		drive_ldst(2'd3, core_pkg::LDST_LOAD, core_pkg::AM_REG_REG, ent[3]);
		drive_miss(2'd2, line_adr ^ 32'h0000_1000, line_ent);
		exp_q.push_back(ent[3]);
		exp_q.push_back(line_ent);
		next_cycle();
		wait_idle();

		// Held off by full memory and then drained round-robin after thread 3
		test_name = "backpressure";
		mem_full = 1'b1;
		drive_ldst(2'd1, core_pkg::LDST_LOADU, core_pkg::AM_REG_IMM, ent[1]);
		next_cycle();
		drive_ldst(2'd2, core_pkg::LDST_STORE, core_pkg::AM_REG_REG, ent[2]);
		drive_miss(2'd3, line_adr ^ 32'h0004_0000, line_ent);
		next_cycle();
		drive_ldst(2'd0, core_pkg::LDST_LOAD, core_pkg::AM_REG_IMM, ent[0]);
		next_cycle();
		exp_q.push_back(ent[0]);
		exp_q.push_back(ent[1]);
		exp_q.push_back(ent[2]);
		exp_q.push_back(line_ent);
		repeat (8) next_cycle();
		mem_full = 1'b0;
		wait_idle();

		$display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(CLK_NS * (TEST_CYCLES + SLACK_CYCLES));
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

endmodule

// ==== src.f ====
logic/mem_bus_pkg.sv
logic/core_pkg.sv
logic/icache_miss_req.sv
logic/ldst_agen.sv
logic/mem_req_arbiter.sv
logic/mem_front_top.sv
sim/tb_clock.sv
sim/tb_mem_front.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the memory front-end testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_mem_front \
	-o tb_mem_front > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_mem_front > sim.log 2>&1 || echo "simulator returned an error status"
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
